/* logic/arp_params.svh */
`ifndef ARP_PARAMS_SVH
`define ARP_PARAMS_SVH

// Learned address pairs held in the table
`define ARP_TABLE_DEPTH 4

// Cycles to wait for a reply after a request goes out
`define ARP_TIMEOUT_TICKS 64

`define ARP_HDR_BYTES 28

`endif

/* logic/arp_pkg.sv */
`include "arp_params.svh"

package arp_pkg;

  typedef logic [3:0][7:0] ipv4_t;     // MSB first
  typedef logic [5:0][7:0] mac_addr_t;

  // Fields in wire order, first byte at the top
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_addr_t   sender_mac;
    ipv4_t       sender_ipv4;
    mac_addr_t   target_mac;
    ipv4_t       target_ipv4;
  } arp_hdr_t;

  // Byte view shifts on the wire, struct view decodes
  typedef union packed {
    arp_hdr_t                          hdr;
    logic [`ARP_HDR_BYTES-1:0][7:0]    bytes;
  } arp_hdr_u;

  localparam logic [15:0] ARP_OPER_REQUEST = 16'd1;
  localparam logic [15:0] ARP_OPER_REPLY   = 16'd2;

  localparam logic [15:0] ARP_HW_ETH   = 16'd1;
  localparam logic [15:0] ARP_PROTO_IP = 16'h0800;
  localparam logic [7:0]  ARP_HLEN     = 8'd6;
  localparam logic [7:0]  ARP_PLEN     = 8'd4;

endpackage

/* logic/arp_rx_if.sv */
`timescale 1ns/10ps

interface arp_rx_if
  import arp_pkg::*;
();

  ipv4_t     peer_ipv4;
  mac_addr_t peer_mac;
  logic      learn;     // Valid ARP packet seen
  logic      reply_due; // Request for local address

  modport src        (output peer_ipv4, peer_mac, learn, reply_due);
  modport learn_sink (input learn, peer_ipv4, peer_mac);
  modport reply_sink (input reply_due, peer_ipv4, peer_mac);

endinterface

/* logic/arp_rx.sv */
`timescale 1ns/10ps
`include "arp_params.svh"

module arp_rx
  import arp_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  ipv4_t      local_ipv4,
  input  logic [7:0] rx_dat,
  input  logic       rx_val,
  input  logic       rx_err,
  arp_rx_if.src      peer
);

  localparam logic [4:0] LAST_BYTE = 5'(`ARP_HDR_BYTES - 1);

  arp_hdr_u   hdr_q;
  arp_hdr_u   hdr_d;
  logic [4:0] byte_cnt;
  logic       skip;      // Rest of frame is ignored
  logic       take_last;
  logic       fields_ok;
  logic       is_request;

  always_comb begin
    hdr_d.bytes = {hdr_q.bytes[`ARP_HDR_BYTES-2:0], rx_dat};
  end

  assign take_last  = rx_val && !rx_err && !skip && (byte_cnt == LAST_BYTE);
  assign is_request = (hdr_d.hdr.oper == ARP_OPER_REQUEST);

  assign fields_ok = (hdr_d.hdr.hw_type == ARP_HW_ETH) &&
                     (hdr_d.hdr.proto == ARP_PROTO_IP) &&
                     (hdr_d.hdr.hlen == ARP_HLEN) &&
                     (hdr_d.hdr.plen == ARP_PLEN) &&
                     (is_request || (hdr_d.hdr.oper == ARP_OPER_REPLY));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt        <= '0;
      skip            <= 1'b0;
      peer.learn      <= 1'b0;
      peer.reply_due  <= 1'b0;
    end else begin
      peer.learn     <= take_last && fields_ok;
      peer.reply_due <= take_last && fields_ok && is_request &&
                        (hdr_d.hdr.target_ipv4 == local_ipv4);
      if (!rx_val) begin // Gap between frames
        byte_cnt <= '0;
        skip     <= 1'b0;
      end else if (rx_err || take_last) begin
        skip <= 1'b1;
      end else if (!skip) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_val && !skip) begin
      hdr_q <= hdr_d;
    end
    if (take_last && fields_ok) begin // Held until next strobe
      peer.peer_ipv4 <= hdr_d.hdr.sender_ipv4;
      peer.peer_mac  <= hdr_d.hdr.sender_mac;
    end
  end

  // At most one strobe per frame
  a_strobe_spacing: assert property (@(posedge clk) disable iff (fsm_rst)
    (peer.learn || peer.reply_due) |=> !(peer.learn || peer.reply_due))
    else $error("arp_rx strobes in consecutive cycles");

endmodule

/* logic/arp_tx.sv */
`timescale 1ns/10ps
`include "arp_params.svh"

module arp_tx
  import arp_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  input  mac_addr_t    local_mac,
  input  ipv4_t        local_ipv4,
  arp_rx_if.reply_sink reply,
  input  logic         req,
  input  ipv4_t        req_ipv4,
  output logic [7:0]   tx_dat,
  output logic         tx_val,
  output logic         tx_last,
  output mac_addr_t    tx_dst_mac
);

  localparam logic [4:0] PRE_LAST = 5'(`ARP_HDR_BYTES - 2);

  logic       reply_pend;
  ipv4_t      reply_ipv4;
  mac_addr_t  reply_mac;
  logic       req_pend;
  ipv4_t      req_ipv4_q;
  logic       take;
  arp_hdr_u   frame;
  arp_hdr_u   shreg;
  logic [4:0] byte_cnt;

  assign take = !tx_val && (reply_pend || req_pend);

  always_comb begin
    frame.hdr.hw_type     = ARP_HW_ETH;
    frame.hdr.proto       = ARP_PROTO_IP;
    frame.hdr.hlen        = ARP_HLEN;
    frame.hdr.plen        = ARP_PLEN;
    frame.hdr.sender_mac  = local_mac;
    frame.hdr.sender_ipv4 = local_ipv4;
    if (reply_pend) begin // Reply wins
      frame.hdr.oper        = ARP_OPER_REPLY;
      frame.hdr.target_mac  = reply_mac;
      frame.hdr.target_ipv4 = reply_ipv4;
    end else begin
      frame.hdr.oper        = ARP_OPER_REQUEST;
      frame.hdr.target_mac  = '0;
      frame.hdr.target_ipv4 = req_ipv4_q;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      reply_pend <= 1'b0;
      req_pend   <= 1'b0;
      tx_val     <= 1'b0;
      tx_last    <= 1'b0;
      byte_cnt   <= '0;
    end else begin
      if (take) begin
        tx_val   <= 1'b1;
        tx_last  <= 1'b0;
        byte_cnt <= '0;
        if (reply_pend) begin
          reply_pend <= 1'b0;
        end else begin
          req_pend <= 1'b0;
        end
      end else if (tx_val) begin
        byte_cnt <= byte_cnt + 1'b1;
        tx_last  <= (byte_cnt == PRE_LAST);
        if (tx_last) begin
          tx_val <= 1'b0;
        end
      end
      // New strobe overrides a clear in the same cycle
      if (reply.reply_due) begin
        reply_pend <= 1'b1;
      end
      if (req) begin
        req_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reply.reply_due) begin
      reply_ipv4 <= reply.peer_ipv4;
      reply_mac  <= reply.peer_mac;
    end
    if (req) begin
      req_ipv4_q <= req_ipv4;
    end
    if (take) begin
      shreg      <= frame;
      tx_dst_mac <= reply_pend ? reply_mac : '1; // Requests go to broadcast
    end else if (tx_val) begin
      shreg.bytes <= {shreg.bytes[`ARP_HDR_BYTES-2:0], 8'h00};
    end
  end

  assign tx_dat = shreg.bytes[`ARP_HDR_BYTES-1];

  a_last_in_frame: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_last |-> tx_val)
    else $error("arp_tx tx_last outside a frame");

endmodule

/* logic/arp_table.sv */
`timescale 1ns/10ps
`include "arp_params.svh"

module arp_table
  import arp_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  arp_rx_if.learn_sink learn,
  input  logic         lookup_req,
  input  ipv4_t        lookup_ipv4,
  output logic         lookup_val,
  output mac_addr_t    lookup_mac,
  output logic         lookup_err,
  output logic         req,
  output ipv4_t        req_ipv4
);

  localparam int DEPTH = `ARP_TABLE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int TMO_W = $clog2(`ARP_TIMEOUT_TICKS);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`ARP_TIMEOUT_TICKS - 1);

  logic [DEPTH-1:0] valid;
  ipv4_t            ent_ipv4 [DEPTH];
  mac_addr_t        ent_mac  [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [DEPTH-1:0] learn_hit;
  logic [DEPTH-1:0] look_hit;
  mac_addr_t        hit_mac;
  logic             learn_known;
  logic             waiting;   // Miss outstanding
  logic [TMO_W-1:0] tmo_cnt;
  logic             reply_match;

  // Parallel compare of all entries
  always_comb begin
    hit_mac = '0;
    for (int i = 0; i < DEPTH; i++) begin
      learn_hit[i] = valid[i] && (ent_ipv4[i] == learn.peer_ipv4);
      look_hit[i]  = valid[i] && (ent_ipv4[i] == lookup_ipv4);
      if (look_hit[i]) begin
        hit_mac = ent_mac[i];
      end
    end
  end

  assign learn_known = |learn_hit;
  assign reply_match = learn.learn && (learn.peer_ipv4 == req_ipv4);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      valid      <= '0;
      wr_ptr     <= '0;
      waiting    <= 1'b0;
      req        <= 1'b0;
      lookup_val <= 1'b0;
      lookup_err <= 1'b0;
    end else begin
      req        <= 1'b0;
      lookup_val <= 1'b0;
      lookup_err <= 1'b0;
      if (learn.learn && !learn_known) begin // New address, round robin
        valid[wr_ptr] <= 1'b1;
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (!waiting) begin
        if (lookup_req && |look_hit) begin
          lookup_val <= 1'b1;
        end else if (lookup_req) begin
          req     <= 1'b1;
          waiting <= 1'b1;
        end
      end else if (reply_match) begin
        lookup_val <= 1'b1;
        waiting    <= 1'b0;
      end else if (tmo_cnt == TMO_LAST) begin
        lookup_err <= 1'b1;
        waiting    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (learn.learn && (learn_known ? learn_hit[i] : (wr_ptr == PTR_W'(i)))) begin
        ent_ipv4[i] <= learn.peer_ipv4;
        ent_mac[i]  <= learn.peer_mac;
      end
    end
    if (!waiting && lookup_req) begin
      lookup_mac <= hit_mac;
      req_ipv4   <= lookup_ipv4;
      tmo_cnt    <= '0;
    end else if (waiting) begin
      lookup_mac <= learn.peer_mac;
      tmo_cnt    <= tmo_cnt + 1'b1;
    end
  end

  a_one_result: assert property (@(posedge clk) disable iff (fsm_rst)
    !(lookup_val && lookup_err))
    else $error("arp_table lookup_val and lookup_err together");

  // Request goes out on the first cycle of a wait
  a_req_from_idle: assert property (@(posedge clk) disable iff (fsm_rst)
    req |-> waiting && !$past(waiting))
    else $error("arp_table req outside idle");

endmodule

/* logic/arp_top.sv */
`timescale 1ns/10ps

module arp_top
  import arp_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  mac_addr_t  local_mac,
  input  ipv4_t      local_ipv4,
  input  logic [7:0] rx_dat,
  input  logic       rx_val,
  input  logic       rx_err,
  output logic [7:0] tx_dat,
  output logic       tx_val,
  output logic       tx_last,
  output mac_addr_t  tx_dst_mac,
  input  logic       lookup_req,
  input  ipv4_t      lookup_ipv4,
  output logic       lookup_val,
  output mac_addr_t  lookup_mac,
  output logic       lookup_err
);

  logic  req;
  ipv4_t req_ipv4;

  arp_rx_if rx_if ();

  arp_rx u_arp_rx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .local_ipv4 (local_ipv4),
    .rx_dat     (rx_dat),
    .rx_val     (rx_val),
    .rx_err     (rx_err),
    .peer       (rx_if)
  );

  arp_tx u_arp_tx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .local_mac  (local_mac),
    .local_ipv4 (local_ipv4),
    .reply      (rx_if),
    .req        (req),
    .req_ipv4   (req_ipv4),
    .tx_dat     (tx_dat),
    .tx_val     (tx_val),
    .tx_last    (tx_last),
    .tx_dst_mac (tx_dst_mac)
  );

  arp_table u_arp_table (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .learn       (rx_if),
    .lookup_req  (lookup_req),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_val  (lookup_val),
    .lookup_mac  (lookup_mac),
    .lookup_err  (lookup_err),
    .req         (req),
    .req_ipv4    (req_ipv4)
  );

endmodule

/* bench/arp_tb.sv */
`timescale 1ns/10ps
`include "arp_params.svh"

module arp_tb
  import arp_pkg::*;
();

  localparam logic [1:0] INJ = 2'd0, LOOK = 2'd1;
  localparam logic [1:0] NONE = 2'd0, REPLY = 2'd1, REQUEST = 2'd2; // Expected tx frame
  localparam logic [1:0] HIT = 2'd1, GOT_REPLY = 2'd2, TIMEOUT = 2'd3;
  localparam logic [2:0] CLEAN = 3'd0, BAD_HLEN = 3'd1, BAD_PROTO = 3'd2;
  localparam logic [2:0] RX_ERR = 3'd3, TRUNC = 3'd4;

  localparam mac_addr_t LOC_MAC  = 48'h02_00_00_00_00_01;
  localparam ipv4_t     LOC_IP   = 32'h0a_00_00_01;
  localparam ipv4_t     OTHER_IP = 32'h0a_00_00_63;
  localparam mac_addr_t MAC_A = 48'h02_00_00_00_00_0a, MAC_B = 48'h02_00_00_00_00_0b;
  localparam mac_addr_t MAC_C = 48'h02_00_00_00_00_0c, MAC_D = 48'h02_00_00_00_00_0d;
  localparam mac_addr_t MAC_E = 48'h02_00_00_00_00_0e, MAC_C2 = 48'h02_00_00_00_01_0c;

  typedef struct packed {
    logic [1:0]  act;
    logic [15:0] oper;
    logic [2:0]  flaw;
    ipv4_t       ip;   // Sender or looked up address
    mac_addr_t   mac;  // Sender or expected MAC
    ipv4_t       tip;
    logic [1:0]  tx;
    logic [1:0]  look;
  } row_t;

  logic       clk = 1'b0;
  logic       fsm_rst;
  mac_addr_t  local_mac;
  ipv4_t      local_ipv4;
  logic [7:0] rx_dat;
  logic       rx_val;
  logic       rx_err;
  logic [7:0] tx_dat;
  logic       tx_val;
  logic       tx_last;
  mac_addr_t  tx_dst_mac;
  logic       lookup_req;
  ipv4_t      lookup_ipv4;
  logic       lookup_val;
  mac_addr_t  lookup_mac;
  logic       lookup_err;

  row_t         rows [$];
  logic [223:0] tx_q [$];
  mac_addr_t    dst_q [$];
  logic [223:0] cur;
  int           nbytes = 0;
  int           errors = 0;
  logic         timed_out = 1'b0;

  arp_top u_arp_top (.*);

  always #50 clk = ~clk;

  task automatic check(input logic [223:0] got, input logic [223:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [223:0] make_hdr(input logic [15:0] oper, input logic [15:0] proto,
      input logic [7:0] hlen, input mac_addr_t smac, input ipv4_t sip,
      input mac_addr_t tmac, input ipv4_t tip);
    return {16'd1, proto, hlen, 8'd4, oper, smac, sip, tmac, tip};
  endfunction

  // Collect whole tx frames
  always @(negedge clk) begin
    if (!fsm_rst && tx_val) begin
      cur = {cur[215:0], tx_dat};
      nbytes = nbytes + 1;
      if (tx_last) begin
        check(nbytes, `ARP_HDR_BYTES, "tx frame length");
        tx_q.push_back(cur);
        dst_q.push_back(tx_dst_mac);
        nbytes = 0;
      end
    end
  end

  task automatic wait_frames(input int limit);
    for (int i = 0; i < limit && tx_q.size() == 0; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_lookup(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(lookup_val || lookup_err) && n < 200);
    if (!(lookup_val || lookup_err)) begin
      $display("timeout at %0t: no lookup result arrived", $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic inject(input row_t r, input int pad);
    logic [223:0] hdr;
    int           nb;
    hdr = make_hdr(r.oper, (r.flaw == BAD_PROTO) ? 16'h0806 : 16'h0800,
                   (r.flaw == BAD_HLEN) ? 8'd5 : 8'd6, r.mac, r.ip,
                   (r.oper == ARP_OPER_REPLY) ? LOC_MAC : '0, r.tip);
    nb = (r.flaw == TRUNC) ? 20 : `ARP_HDR_BYTES + pad;
    for (int i = 0; i < nb; i++) begin
      @(posedge clk);
      rx_dat <= (i < `ARP_HDR_BYTES) ? hdr[223 - 8*i -: 8] : 8'($urandom);
      rx_val <= 1'b1;
      rx_err <= (r.flaw == RX_ERR) && (i == 10);
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_err <= 1'b0;
  endtask

  task automatic lookup(input row_t r);
    row_t rep;
    int   n;
    rep = row_t'{INJ, ARP_OPER_REPLY, CLEAN, r.ip, r.mac, LOC_IP, NONE, 2'd0};
    @(posedge clk);
    lookup_req  <= 1'b1;
    lookup_ipv4 <= r.ip;
    @(posedge clk);
    lookup_req <= 1'b0;
    if (r.look == HIT) begin
      @(negedge clk);
      check(lookup_val, 1'b1, "lookup hit valid");
      check(lookup_mac, r.mac, "lookup hit mac");
    end else if (r.look == GOT_REPLY) begin
      wait_frames(60); // Peer answers our request
      inject(rep, 0);
      wait_lookup(n);
      check(n, 2, "cycles from reply to lookup_val");
      check(lookup_val, 1'b1, "lookup valid after reply");
      check(lookup_mac, r.mac, "lookup mac after reply");
    end else begin
      wait_lookup(n); // req is seen at n == 1
      check(n, 1 + `ARP_TIMEOUT_TICKS, "cycles from request to lookup_err");
      check(lookup_err, 1'b1, "lookup_err on timeout");
      check(lookup_val, 1'b0, "no lookup_val on timeout");
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [223:0] exp;
    if (r.act == INJ) begin
      inject(r, $urandom % 3);
    end else begin
      lookup(r);
    end
    wait_frames(40);
    check(tx_q.size(), r.tx != NONE, "tx frame count");
    if (r.tx != NONE && tx_q.size() > 0) begin
      exp = (r.tx == REPLY) ?
            make_hdr(ARP_OPER_REPLY, 16'h0800, 8'd6, LOC_MAC, LOC_IP, r.mac, r.ip) :
            make_hdr(ARP_OPER_REQUEST, 16'h0800, 8'd6, LOC_MAC, LOC_IP, '0, r.ip);
      check(tx_q[0], exp, "tx header");
      check(dst_q[0], (r.tx == REPLY) ? r.mac : 48'hffff_ffff_ffff, "tx_dst_mac");
    end
    tx_q.delete();
    dst_q.delete();
  endtask

  task automatic load_rows();
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, CLEAN, 32'h0a000002, MAC_A, LOC_IP, REPLY, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000002, MAC_A, 0, NONE, HIT});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, CLEAN, 32'h0a000003, MAC_B, OTHER_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000003, MAC_B, 0, NONE, HIT});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000004, MAC_C, 0, REQUEST, GOT_REPLY});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000005, 0, 0, REQUEST, TIMEOUT});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, BAD_HLEN, 32'h0a000006, MAC_D, LOC_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000006, 0, 0, REQUEST, TIMEOUT});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, BAD_PROTO, 32'h0a000007, MAC_D, LOC_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000007, 0, 0, REQUEST, TIMEOUT});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, RX_ERR, 32'h0a000008, MAC_D, LOC_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000008, 0, 0, REQUEST, TIMEOUT});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, TRUNC, 32'h0a000009, MAC_D, LOC_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000009, 0, 0, REQUEST, TIMEOUT});
    rows.push_back(row_t'{INJ, ARP_OPER_REPLY, CLEAN, 32'h0a00000a, MAC_D, LOC_IP, NONE, 0});
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, CLEAN, 32'h0a00000b, MAC_E, OTHER_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000002, 0, 0, REQUEST, TIMEOUT}); // Evicted
    rows.push_back(row_t'{INJ, ARP_OPER_REQUEST, CLEAN, 32'h0a000004, MAC_C2, OTHER_IP, NONE, 0});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000004, MAC_C2, 0, NONE, HIT});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a000003, MAC_B, 0, NONE, HIT});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a00000a, MAC_D, 0, NONE, HIT});
    rows.push_back(row_t'{LOOK, 0, CLEAN, 32'h0a00000b, MAC_E, 0, NONE, HIT});
  endtask

  initial begin
    void'($urandom(32779));
    fsm_rst     = 1'b1;
    local_mac   = LOC_MAC;
    local_ipv4  = LOC_IP;
    rx_dat      = 8'h00;
    rx_val      = 1'b0;
    rx_err      = 1'b0;
    lookup_req  = 1'b0;
    lookup_ipv4 = '0;
    load_rows();
    repeat (4) @(posedge clk);
    fsm_rst <= 1'b0;
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      apply_row(rows[i]);
    end
    $display("run done: %0d rows, %0d errors, %0d timeouts", rows.size(), errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+logic
logic/arp_pkg.sv
logic/arp_rx_if.sv
logic/arp_rx.sv
logic/arp_tx.sv
logic/arp_table.sv
logic/arp_top.sv
bench/arp_tb.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module arp_tb -f filelist.f
	./obj_dir/Varp_tb > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	! grep -q "TB FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
